// ==== sim/fsa_tests.txt ====
# Frame: height width threshold, then height lines of width pixels (all hex)
# Expected: left_valid left_col right_valid right_col column dark top bot (all hex)
4 8 80
10 ff ff ff ff ff ff 20
ff 30 ff ff 40 ff 50 ff
ff ff 7f 80 ff ff ff ff
00 ff ff 05 ff ff ff ff
1 2 1 6 0 1 0 3
5 6 40
90 90 90 90 90 90
90 90 3f 90 90 90
90 10 90 90 90 90
40 90 90 90 41 90
00 20 90 90 90 00
0 0 0 0 1 1 2 4
6 7 20
80 1f 80 80 80 80 80
80 80 80 1f 80 80 80
00 80 80 80 80 80 80
80 80 05 80 80 80 20
11 80 80 80 80 80 1e
80 80 80 80 10 10 80
1 3 1 6 0 1 2 4

// ==== files.f ====
+incdir+common
common/fsa_pkg.sv
fsa_core/fsa_colmem.sv
fsa_core/fsa_core.sv
verilog/fsa_regs.sv
verilog/fsa_top.sv
sim/fsa_tb.sv

// ==== Bender.yml ====
package:
  name: fsa

sources:
  - include_dirs:
      - common
    files:
      - common/fsa_pkg.sv
      - fsa_core/fsa_colmem.sv
      - fsa_core/fsa_core.sv
      - verilog/fsa_regs.sv
      - verilog/fsa_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/fsa_tb.sv

// ==== sim/fsa_tb.sv ====
`timescale 1ns/1ns
`include "fsa_consts.svh"

module fsa_tb;
	// One frame record of the tests file with its expected results
	typedef struct packed {
		logic [31:0] height;
		logic [31:0] width;
		logic [31:0] thresh;
		logic [31:0] left_valid;
		logic [31:0] left_col;
		logic [31:0] right_valid;
		logic [31:0] right_col;
		logic [31:0] col;
		logic [31:0] dark;
		logic [31:0] top;
		logic [31:0] bot;
	} frame_t;

	logic                  clk;
	logic                  resetn;
	logic                  s_axis_tvalid;
	logic [`FSA_PIX_W-1:0] s_axis_tdata;
	logic                  s_axis_tuser;
	logic                  s_axis_tlast;
	logic                  s_axis_tready;
	logic [7:0]            s_axil_awaddr;
	logic                  s_axil_awvalid;
	logic                  s_axil_awready;
	logic [31:0]           s_axil_wdata;
	logic [3:0]            s_axil_wstrb;
	logic                  s_axil_wvalid;
	logic                  s_axil_wready;
	logic [1:0]            s_axil_bresp;
	logic                  s_axil_bvalid;
	logic                  s_axil_bready;
	logic [7:0]            s_axil_araddr;
	logic                  s_axil_arvalid;
	logic                  s_axil_arready;
	logic [31:0]           s_axil_rdata;
	logic [1:0]            s_axil_rresp;
	logic                  s_axil_rvalid;
	logic                  s_axil_rready;
	logic                  frame_done;

	frame_t                frames_q[$];
	logic [`FSA_PIX_W-1:0] pix_q[$];
	int unsigned           done_cnt = 0;
	int unsigned           limit_cycles = 0;

	fsa_top i_fsa_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!resetn)
			done_cnt <= 0;
		else if (frame_done)
			done_cnt <= done_cnt + 1;
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Run timed out after %0d clock cycles", limit_cycles);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		s_axil_awaddr <= addr;
		s_axil_awvalid <= 1'b1;
		s_axil_wdata <= data;
		s_axil_wstrb <= 4'hF;
		s_axil_wvalid <= 1'b1;
		do @(posedge clk); while (!(s_axil_awready && s_axil_wready));
		s_axil_awvalid <= 1'b0;
		s_axil_wvalid <= 1'b0;
		do @(posedge clk); while (!s_axil_bvalid);  // bready held high
		check_value("s_axil_bresp", 32'd0, 32'(s_axil_bresp));
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		s_axil_araddr <= addr;
		s_axil_arvalid <= 1'b1;
		do @(posedge clk); while (!s_axil_arready);
		s_axil_arvalid <= 1'b0;
		do @(posedge clk); while (!s_axil_rvalid);
		data = s_axil_rdata;
		check_value("s_axil_rresp", 32'd0, 32'(s_axil_rresp));
	endtask

	task automatic stream_frame(input int unsigned height, input int unsigned width);
		int unsigned r;
		int unsigned c;
		for (r = 0; r < height; r++) begin
			for (c = 0; c < width; c++) begin
				while (($urandom % 4) == 0) begin  // Idle gap
					s_axis_tvalid <= 1'b0;
					@(posedge clk);
				end
				s_axis_tvalid <= 1'b1;
				s_axis_tdata <= pix_q.pop_front();
				s_axis_tuser <= (r == 0 && c == 0);
				s_axis_tlast <= (c == width - 1);
				@(posedge clk);
				check_value("s_axis_tready", 32'd1, 32'(s_axis_tready));
			end
		end
		s_axis_tvalid <= 1'b0;
	endtask

	task automatic load_tests();
		int fd;
		int r;
		int i;
		int unsigned total;
		string line;
		logic [31:0] fld [0:10];
		logic [31:0] pix;
		total = 0;
		fd = $fopen("sim/fsa_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the tests file sim/fsa_tests.txt");
			$display("SIMULATION FAILED");
			$fatal(1, "no tests file");
		end
		r = $fgets(line, fd);  // Two header lines
		r = $fgets(line, fd);
		while ($fscanf(fd, "%h", fld[0]) == 1) begin
			r = $fscanf(fd, "%h %h", fld[1], fld[2]);
			for (i = 0; i < fld[0] * fld[1]; i++) begin
				r = $fscanf(fd, "%h", pix);
				pix_q.push_back(pix[`FSA_PIX_W-1:0]);
			end
			for (i = 3; i < 11; i++)
				r = $fscanf(fd, "%h", fld[i]);
			if (r != 1) begin
				$display("The tests file ends in the middle of a frame record");
				$display("SIMULATION FAILED");
				$fatal(1, "short tests file");
			end
			frames_q.push_back({fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
				fld[6], fld[7], fld[8], fld[9], fld[10]});
			total += fld[0] * fld[1];
		end
		$fclose(fd);
		if (frames_q.size() == 0) begin
			$display("The tests file holds no frames");
			$display("SIMULATION FAILED");
			$fatal(1, "empty tests file");
		end
		limit_cycles = 200 + 4 * total;
	endtask

	task automatic run_frame(input frame_t f, input int unsigned num);
		logic [31:0] word;
		write_reg(`FSA_REG_HEIGHT, f.height);
		write_reg(`FSA_REG_WIDTH, f.width);
		write_reg(`FSA_REG_THRESH, f.thresh);
		write_reg(`FSA_REG_COL_SEL, f.col);
		stream_frame(f.height, f.width);
		while (done_cnt != num)
			@(posedge clk);
		read_reg(`FSA_REG_LEFT, word);
		check_value("LEFT", {f.left_valid[0], 19'd0, f.left_col[11:0]}, word);
		read_reg(`FSA_REG_RIGHT, word);
		check_value("RIGHT", {f.right_valid[0], 19'd0, f.right_col[11:0]}, word);
		read_reg(`FSA_REG_COL_DATA, word);
		check_value("COL_DATA", {7'd0, f.dark[0], f.top[11:0], f.bot[11:0]}, word);
		read_reg(`FSA_REG_FRAMES, word);
		check_value("FRAMES", num, word);
		check_value("frame_done", num, done_cnt);  // Exactly one pulse per frame
	endtask

	initial begin
		logic [31:0] word;
		int n;
		resetn = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b1;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b1;
		void'($urandom(48));
		load_tests();
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		read_reg(`FSA_REG_FRAMES, word);
		check_value("FRAMES", 32'd0, word);
		read_reg(`FSA_REG_LEFT, word);
		check_value("LEFT", 32'd0, word);
		write_reg(`FSA_REG_HEIGHT, 32'h123);
		read_reg(`FSA_REG_HEIGHT, word);
		check_value("HEIGHT", 32'h123, word);
		write_reg(`FSA_REG_WIDTH, 32'h456);
		read_reg(`FSA_REG_WIDTH, word);
		check_value("WIDTH", 32'h456, word);
		write_reg(`FSA_REG_THRESH, 32'ha5);
		read_reg(`FSA_REG_THRESH, word);
		check_value("THRESH", 32'ha5, word);
		write_reg(`FSA_REG_COL_SEL, 32'h9);
		read_reg(`FSA_REG_COL_SEL, word);
		check_value("COL_SEL", 32'h9, word);
		for (n = 0; n < frames_q.size(); n++)
			run_frame(frames_q[n], n + 1);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== verilog/fsa_top.sv ====
`timescale 1ns/1ns
`include "fsa_consts.svh"

module fsa_top (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  s_axis_tvalid,
	input  logic [`FSA_PIX_W-1:0] s_axis_tdata,
	input  logic                  s_axis_tuser,
	input  logic                  s_axis_tlast,
	output logic                  s_axis_tready,
	input  logic [7:0]            s_axil_awaddr,
	input  logic                  s_axil_awvalid,
	output logic                  s_axil_awready,
	input  logic [31:0]           s_axil_wdata,
	input  logic [3:0]            s_axil_wstrb,
	input  logic                  s_axil_wvalid,
	output logic                  s_axil_wready,
	output logic [1:0]            s_axil_bresp,
	output logic                  s_axil_bvalid,
	input  logic                  s_axil_bready,
	input  logic [7:0]            s_axil_araddr,
	input  logic                  s_axil_arvalid,
	output logic                  s_axil_arready,
	output logic [31:0]           s_axil_rdata,
	output logic [1:0]            s_axil_rresp,
	output logic                  s_axil_rvalid,
	input  logic                  s_axil_rready,
	output logic                  frame_done
);
	fsa_pkg::pix_beat_t    axis_beat;
	fsa_pkg::fsa_cfg_t     cfg;
	fsa_pkg::col_state_t   rd_data;
	fsa_pkg::col_state_t   wr_data;
	fsa_pkg::col_state_t   col_data;
	fsa_pkg::edge_t        left_edge;
	fsa_pkg::edge_t        right_edge;
	logic                  rd_en;
	logic                  wr_en;
	logic [`FSA_COL_W-1:0] rd_addr;
	logic [`FSA_COL_W-1:0] wr_addr;
	logic [`FSA_COL_W-1:0] col_addr;

	assign axis_beat = '{data: s_axis_tdata, sof: s_axis_tuser, eol: s_axis_tlast};

	fsa_regs i_fsa_regs (
		.clk(clk), .resetn(resetn),
		.s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready), .s_axil_wdata(s_axil_wdata),
		.s_axil_wstrb(s_axil_wstrb), .s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready), .s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready), .s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp), .s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready), .cfg(cfg),
		.left_edge(left_edge), .right_edge(right_edge), .frame_done(frame_done),
		.col_addr(col_addr), .col_data(col_data)
	);

	fsa_core i_fsa_core (
		.clk(clk), .resetn(resetn), .cfg(cfg),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tdata(axis_beat.data),
		.s_axis_tuser(axis_beat.sof), .s_axis_tlast(axis_beat.eol),
		.s_axis_tready(s_axis_tready),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.left_edge(left_edge), .right_edge(right_edge), .frame_done(frame_done)
	);

	fsa_colmem i_fsa_colmem (
		.clk(clk),
		.a_en(rd_en), .a_addr(rd_addr), .a_data(rd_data),
		.w_en(wr_en), .w_addr(wr_addr), .w_data(wr_data),
		.b_addr(col_addr), .b_data(col_data)
	);

endmodule

// ==== verilog/fsa_regs.sv ====
`timescale 1ns/1ns
`include "fsa_consts.svh"

module fsa_regs (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [7:0]            s_axil_awaddr,
	input  logic                  s_axil_awvalid,
	output logic                  s_axil_awready,
	input  logic [31:0]           s_axil_wdata,
	input  logic [3:0]            s_axil_wstrb,
	input  logic                  s_axil_wvalid,
	output logic                  s_axil_wready,
	output logic [1:0]            s_axil_bresp,
	output logic                  s_axil_bvalid,
	input  logic                  s_axil_bready,
	input  logic [7:0]            s_axil_araddr,
	input  logic                  s_axil_arvalid,
	output logic                  s_axil_arready,
	output logic [31:0]           s_axil_rdata,
	output logic [1:0]            s_axil_rresp,
	output logic                  s_axil_rvalid,
	input  logic                  s_axil_rready,
	output fsa_pkg::fsa_cfg_t     cfg,
	input  fsa_pkg::edge_t        left_edge,
	input  fsa_pkg::edge_t        right_edge,
	input  logic                  frame_done,
	output logic [`FSA_COL_W-1:0] col_addr,
	input  fsa_pkg::col_state_t   col_data
);
	logic [7:0]  aw_addr_q;
	logic [7:0]  ar_addr_q;
	logic [31:0] wdata_q;
	logic [3:0]  wstrb_q;
	logic [1:0]  wr_sh;
	logic [1:0]  rd_sh;
	logic [31:0] frames;
	logic [31:0] wmask;
	logic [31:0] wr_word;
	logic        aw_hs;
	logic        ar_hs;

	function automatic logic [31:0] reg_word(input logic [7:0] addr);
		case (addr)
			`FSA_REG_HEIGHT:   reg_word = 32'(cfg.height);
			`FSA_REG_WIDTH:    reg_word = 32'(cfg.width);
			`FSA_REG_THRESH:   reg_word = 32'(cfg.thresh);
			`FSA_REG_LEFT:     reg_word = {left_edge.valid, {(31-`FSA_COL_W){1'b0}}, left_edge.col};
			`FSA_REG_RIGHT:    reg_word = {right_edge.valid, {(31-`FSA_COL_W){1'b0}}, right_edge.col};
			`FSA_REG_FRAMES:   reg_word = frames;
			`FSA_REG_COL_SEL:  reg_word = 32'(col_addr);
			`FSA_REG_COL_DATA: reg_word = 32'(col_data);
			default:           reg_word = '0;
		endcase
	endfunction

	// AW and W are taken together, one access in flight per direction
	assign s_axil_awready = s_axil_awvalid & s_axil_wvalid & ~|wr_sh & ~s_axil_bvalid;
	assign s_axil_wready = s_axil_awready;
	assign aw_hs = s_axil_awvalid & s_axil_awready;
	assign s_axil_arready = ~|rd_sh & ~s_axil_rvalid;
	assign ar_hs = s_axil_arvalid & s_axil_arready;
	assign s_axil_bresp = 2'b00;
	assign s_axil_rresp = 2'b00;

	always_comb begin
		wmask = {{8{wstrb_q[3]}}, {8{wstrb_q[2]}}, {8{wstrb_q[1]}}, {8{wstrb_q[0]}}};
		wr_word = (reg_word(aw_addr_q) & ~wmask) | (wdata_q & wmask);
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			aw_addr_q <= s_axil_awaddr;
			wdata_q <= s_axil_wdata;
			wstrb_q <= s_axil_wstrb;
		end
		if (ar_hs)
			ar_addr_q <= s_axil_araddr;
		if (rd_sh[1])
			s_axil_rdata <= reg_word(ar_addr_q);  // COL_DATA settled by now
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_sh <= '0;
			rd_sh <= '0;
			s_axil_bvalid <= 1'b0;
			s_axil_rvalid <= 1'b0;
			cfg <= '0;
			col_addr <= '0;
			frames <= '0;
		end else begin
			wr_sh <= {wr_sh[0], aw_hs};
			rd_sh <= {rd_sh[0], ar_hs};
			if (wr_sh[0]) begin
				case (aw_addr_q)
					`FSA_REG_HEIGHT:  cfg.height <= wr_word[`FSA_ROW_W-1:0];
					`FSA_REG_WIDTH:   cfg.width <= wr_word[`FSA_COL_W-1:0];
					`FSA_REG_THRESH:  cfg.thresh <= wr_word[`FSA_PIX_W-1:0];
					`FSA_REG_COL_SEL: col_addr <= wr_word[`FSA_COL_W-1:0];
					default:          ;
				endcase
			end
			if (wr_sh[1])
				s_axil_bvalid <= 1'b1;
			else if (s_axil_bready)
				s_axil_bvalid <= 1'b0;
			if (rd_sh[1])
				s_axil_rvalid <= 1'b1;
			else if (s_axil_rready)
				s_axil_rvalid <= 1'b0;
			if (frame_done)
				frames <= frames + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

	assert property (@(posedge clk) disable iff (!resetn)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== fsa_core/fsa_core.sv ====
`timescale 1ns/1ns
`include "fsa_consts.svh"

module fsa_core (
	input  logic                  clk,
	input  logic                  resetn,
	input  fsa_pkg::fsa_cfg_t     cfg,
	input  logic                  s_axis_tvalid,
	input  logic [`FSA_PIX_W-1:0] s_axis_tdata,
	input  logic                  s_axis_tuser,
	input  logic                  s_axis_tlast,
	output logic                  s_axis_tready,
	output logic                  rd_en,
	output logic [`FSA_COL_W-1:0] rd_addr,
	input  fsa_pkg::col_state_t   rd_data,
	output logic                  wr_en,
	output logic [`FSA_COL_W-1:0] wr_addr,
	output fsa_pkg::col_state_t   wr_data,
	output fsa_pkg::edge_t        left_edge,
	output fsa_pkg::edge_t        right_edge,
	output logic                  frame_done
);
	typedef struct packed {
		logic                  vld;
		logic                  dark;
		logic                  first;
		logic                  last;
		logic                  eol;
		logic [`FSA_COL_W-1:0] x;
		logic [`FSA_ROW_W-1:0] y;
	} stage_t;

	fsa_pkg::pix_beat_t    beat;
	fsa_pkg::pix_beat_t    b0;
	logic                  axis_hs;
	logic [`FSA_COL_W-1:0] x_cnt;
	logic [`FSA_COL_W-1:0] cur_x;
	logic [`FSA_ROW_W-1:0] y_cnt;
	logic [`FSA_ROW_W-1:0] cur_y;
	logic [`FSA_ROW_W-1:0] y0;
	stage_t                s1;
	stage_t                s2;
	stage_t                s3;
	fsa_pkg::col_state_t   old2;
	fsa_pkg::col_state_t   old3;
	fsa_pkg::col_state_t   old_s;
	fsa_pkg::col_state_t   nxt;
	logic                  sof4;
	logic                  sof5;
	logic                  lft_run;
	logic                  lft_valid;
	logic [`FSA_COL_W-1:0] lft_col;
	logic                  rt_prev;
	logic                  rt_valid;
	logic [`FSA_COL_W-1:0] rt_col;

	assign s_axis_tready = 1'b1;
	assign axis_hs = s_axis_tvalid & s_axis_tready;
	assign beat = '{data: s_axis_tdata, sof: s_axis_tuser, eol: s_axis_tlast};
	assign cur_x = beat.sof ? '0 : x_cnt;
	assign cur_y = beat.sof ? '0 : y_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			rd_en <= axis_hs;  // Read issued with the captured beat
			if (axis_hs) begin
				x_cnt <= beat.eol ? '0 : cur_x + 1'b1;
				y_cnt <= beat.eol ? cur_y + 1'b1 : cur_y;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (axis_hs) begin
			rd_addr <= cur_x;
			y0 <= cur_y;
			b0 <= beat;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			s1 <= '0;
			s2 <= '0;
			s3 <= '0;
		end else begin
			s1.vld <= rd_en;
			s1.dark <= b0.data < cfg.thresh;
			s1.first <= y0 == '0;
			s1.last <= y0 == cfg.height - 1'b1;
			s1.eol <= b0.eol;
			s1.x <= rd_addr;
			s1.y <= y0;
			s2 <= s1;
			s3 <= s2;
		end
	end

	// Memory output lines up with stage 2
	always_ff @(posedge clk) begin
		old2 <= rd_data;
		old3 <= old2;
	end

	always_comb begin
		old_s = s3.first ? '0 : old3;
		nxt.dark = old_s.dark | s3.dark;
		nxt.top = (s3.dark && !old_s.dark) ? s3.y : old_s.top;
		nxt.bot = s3.dark ? s3.y : old_s.bot;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_en <= 1'b0;
			sof4 <= 1'b0;
			sof5 <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			wr_en <= s3.vld;
			sof4 <= s3.vld & s3.last & s3.eol;  // Last beat of the frame
			sof5 <= sof4;
			frame_done <= sof5;
		end
	end

	always_ff @(posedge clk) begin
		if (s3.vld) begin
			wr_addr <= s3.x;
			wr_data <= nxt;
		end
	end

	// Edge scan over the flags of the earlier rows, during the last row
	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_run <= 1'b0;
			lft_valid <= 1'b0;
			lft_col <= '0;
			rt_prev <= 1'b0;
			rt_valid <= 1'b0;
			rt_col <= '0;
		end else if (s3.vld && s3.last) begin
			if (s3.x == '0) begin
				lft_valid <= old3.dark;
				lft_run <= old3.dark;
				lft_col <= '0;
			end else if (!old3.dark) begin
				lft_run <= 1'b0;
			end else if (lft_run) begin
				lft_col <= s3.x;
			end
			if (old3.dark && (s3.x == '0 || !rt_prev))
				rt_col <= s3.x;  // Start of a new dark run
			rt_prev <= old3.dark;
			if (s3.eol)
				rt_valid <= old3.dark;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			left_edge <= '0;
			right_edge <= '0;
		end else if (sof4) begin
			left_edge.valid <= lft_valid;
			left_edge.col <= lft_valid ? lft_col : '0;
			right_edge.valid <= rt_valid;
			right_edge.col <= rt_valid ? rt_col : '0;
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		wr_en |-> $past(rd_en, 4) && $past(rd_addr, 4) == wr_addr);

	assert property (@(posedge clk) disable iff (!resetn)
		rd_en |-> rd_addr < cfg.width);

endmodule

// ==== fsa_core/fsa_colmem.sv ====
`timescale 1ns/1ns
`include "fsa_consts.svh"

module fsa_colmem #(
	parameter int DEPTH = 1 << `FSA_COL_W
) (
	input  logic                  clk,
	input  logic                  a_en,
	input  logic [`FSA_COL_W-1:0] a_addr,
	output fsa_pkg::col_state_t   a_data,
	input  logic                  w_en,
	input  logic [`FSA_COL_W-1:0] w_addr,
	input  fsa_pkg::col_state_t   w_data,
	input  logic [`FSA_COL_W-1:0] b_addr,
	output fsa_pkg::col_state_t   b_data
);
	fsa_pkg::col_state_t mem_a [DEPTH];  // Pipeline copy
	fsa_pkg::col_state_t mem_b [DEPTH];  // Readback copy

	always_ff @(posedge clk) begin
		if (w_en)
			mem_a[w_addr] <= w_data;
		if (a_en)
			a_data <= mem_a[a_addr];
	end

	always_ff @(posedge clk) begin
		if (w_en)
			mem_b[w_addr] <= w_data;
		b_data <= mem_b[b_addr];
	end

	assert property (@(posedge clk) w_en |-> w_addr < DEPTH);

endmodule

// ==== common/fsa_pkg.sv ====
`include "fsa_consts.svh"

package fsa_pkg;

	// Per-column record kept across the rows of a frame
	typedef struct packed {
		logic                  dark;
		logic [`FSA_ROW_W-1:0] top;
		logic [`FSA_ROW_W-1:0] bot;
	} col_state_t;

	typedef struct packed {
		logic [`FSA_PIX_W-1:0] data;
		logic                  sof;  // tuser
		logic                  eol;  // tlast
	} pix_beat_t;

	typedef struct packed {
		logic                  valid;
		logic [`FSA_COL_W-1:0] col;
	} edge_t;

	typedef struct packed {
		logic [`FSA_ROW_W-1:0] height;
		logic [`FSA_COL_W-1:0] width;
		logic [`FSA_PIX_W-1:0] thresh;
	} fsa_cfg_t;

endpackage

// ==== common/fsa_consts.svh ====
`ifndef FSA_CONSTS_SVH
`define FSA_CONSTS_SVH

`define FSA_PIX_W 8
`define FSA_ROW_W 12
`define FSA_COL_W 12

`define FSA_REG_HEIGHT   8'h00
`define FSA_REG_WIDTH    8'h04
`define FSA_REG_THRESH   8'h08
`define FSA_REG_LEFT     8'h0C
`define FSA_REG_RIGHT    8'h10
`define FSA_REG_FRAMES   8'h14
`define FSA_REG_COL_SEL  8'h18
`define FSA_REG_COL_DATA 8'h1C

`endif
